/* nitta_pkg.sv */
package nitta_pkg;

  // Default data width of a bus word.
  localparam int data_width_default = 8;

  // Register file depth in words.
  localparam int fram_depth_default = 8;

  // Number of microprogram steps.
  localparam int prog_depth_default = 16;

  // Attribute word that travels next to every data word.
  // Only the invalid flag is defined; the spare bits stay zero.
  typedef struct packed {
    logic [2:0] spare;
    logic       invalid;
  } attr_t;

  // Plain strobes of one processing unit.
  typedef struct packed {
    logic wr;
    logic sel;
    logic oe;
  } unit_ctrl_t;

  // Register file strobes with the word address.
  // Four address bits cover the default depth with room to spare.
  typedef struct packed {
    logic       wr;
    logic       oe;
    logic [3:0] addr;
  } fram_ctrl_t;

  // One microprogram step.
  // The last flag marks the final step of a program.
  typedef struct packed {
    fram_ctrl_t fram;
    unit_ctrl_t mult;
    unit_ctrl_t accum;
    logic       last;
  } ctrl_word_t;

endpackage

/* pu_mult_inner.sv */
`timescale 1ns/1ps

module pu_mult_inner
  #( parameter int DATA_WIDTH = 8
   )
  ( input  logic [DATA_WIDTH-1:0] dataa
  , input  logic [DATA_WIDTH-1:0] datab
  , output logic [DATA_WIDTH-1:0] result
  , output logic                  fits
  );

  // Full signed product, twice the data width.
  logic signed [2*DATA_WIDTH-1:0] product;
  // Upper half together with the sign bit of the low word.
  logic        [DATA_WIDTH:0]     high_part;

  assign product = $signed(dataa) * $signed(datab);

  // Only the low word goes back to the bus.
  assign result = product[DATA_WIDTH-1:0];

  // The product fits when the upper half only repeats the sign of the low word.
  assign high_part = product[2*DATA_WIDTH-1:DATA_WIDTH-1];
  assign fits      = (&high_part) | ~(|high_part);

endmodule

/* pu_mult.sv */
`timescale 1ns/1ps

module pu_mult
  #( parameter int DATA_WIDTH = 8
   )
  ( input  logic                  clk
  , input  logic                  rst
  , input  logic                  signal_wr
  , input  logic                  signal_sel
  , input  logic                  signal_oe
  , input  logic [DATA_WIDTH-1:0] data_in
  , input  nitta_pkg::attr_t      attr_in
  , output logic [DATA_WIDTH-1:0] data_out
  , output nitta_pkg::attr_t      attr_out
  );

  // Operand registers, one per sel value.
  logic [DATA_WIDTH-1:0] operand_a;
  logic [DATA_WIDTH-1:0] operand_b;
  // Held invalid flag of the operand pair.
  logic                  operand_invalid;
  // Previous sel, for the falling edge detector.
  logic                  sel_q;
  logic                  capture;
  // Combinational product and its range check.
  logic [DATA_WIDTH-1:0] product;
  logic                  product_fits;
  // Registered result shown on the bus.
  logic [DATA_WIDTH-1:0] result_data;
  logic                  result_invalid;

  pu_mult_inner #(
    .DATA_WIDTH(DATA_WIDTH)
  ) i_mult_inner (
    .dataa (operand_a),
    .datab (operand_b),
    .result(product),
    .fits  (product_fits)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      operand_a       <= '0;
      operand_b       <= '0;
      operand_invalid <= 1'b0;
      sel_q           <= 1'b0;
      capture         <= 1'b0;
      result_data     <= '0;
      result_invalid  <= 1'b0;
    end else begin
      // Capture strobe follows sel going from one to zero.
      sel_q   <= signal_sel;
      capture <= sel_q && !signal_sel;

      if (signal_wr) begin
        if (signal_sel) begin
          // Second operand closes the pair, so its flag is merged in.
          operand_b       <= data_in;
          operand_invalid <= operand_invalid | attr_in.invalid;
        end else begin
          // First operand starts a new pair.
          operand_a       <= data_in;
          operand_invalid <= attr_in.invalid;
        end
      end

      // Result is bad if an operand was bad or the product overflowed.
      if (capture) begin
        result_data    <= product;
        result_invalid <= operand_invalid | ~product_fits;
      end
    end
  end

  // Bus drive is zero unless oe is set, so the top level can OR the units.
  assign data_out = signal_oe ? result_data : '0;

  always_comb begin
    attr_out         = '0;
    attr_out.invalid = signal_oe & result_invalid;
  end

endmodule

/* pu_accum.sv */
`timescale 1ns/1ps

module pu_accum
  #( parameter int DATA_WIDTH = 8
   )
  ( input  logic                  clk
  , input  logic                  rst
  , input  logic                  signal_wr
  , input  logic                  signal_sel
  , input  logic                  signal_oe
  , input  logic [DATA_WIDTH-1:0] data_in
  , input  nitta_pkg::attr_t      attr_in
  , output logic [DATA_WIDTH-1:0] data_out
  , output nitta_pkg::attr_t      attr_out
  );

  // Running sum and its sticky invalid flag.
  logic [DATA_WIDTH-1:0] acc;
  logic                  acc_invalid;
  // Next sum and the signed overflow of that addition.
  logic [DATA_WIDTH-1:0] sum;
  logic                  overflow;

  assign sum = acc + data_in;

  // Overflow when both addends share a sign and the sum does not.
  assign overflow = (acc[DATA_WIDTH-1] == data_in[DATA_WIDTH-1]) &&
                    (sum[DATA_WIDTH-1] != acc[DATA_WIDTH-1]);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc         <= '0;
      acc_invalid <= 1'b0;
    end else if (signal_wr) begin
      if (signal_sel) begin
        // Add; the flag stays set until the next load.
        acc         <= sum;
        acc_invalid <= acc_invalid | overflow | attr_in.invalid;
      end else begin
        // Load replaces both the value and the flag.
        acc         <= data_in;
        acc_invalid <= attr_in.invalid;
      end
    end
  end

  // Zero on the bus unless selected for output.
  assign data_out = signal_oe ? acc : '0;

  always_comb begin
    attr_out         = '0;
    attr_out.invalid = signal_oe & acc_invalid;
  end

endmodule

/* pu_fram.sv */
`timescale 1ns/1ps

module pu_fram
  #( parameter int DATA_WIDTH = 8
   , parameter int FRAM_DEPTH = 8
   )
  ( input  logic                  clk
  , input  logic                  rst
  , input  nitta_pkg::fram_ctrl_t ctrl
  , input  logic [DATA_WIDTH-1:0] data_in
  , input  nitta_pkg::attr_t      attr_in
  , output logic [DATA_WIDTH-1:0] data_out
  , output nitta_pkg::attr_t      attr_out
  , input  logic                  ext_wr
  , input  logic [3:0]            ext_addr
  , input  logic [DATA_WIDTH-1:0] ext_data
  , input  nitta_pkg::attr_t      ext_attr
  , input  logic [3:0]            ext_rd_addr
  , output logic [DATA_WIDTH-1:0] ext_rd_data
  , output nitta_pkg::attr_t      ext_rd_attr
  );

  // Addresses wrap to the memory depth.
  localparam int ADDR_BITS = $clog2(FRAM_DEPTH);

  // Data words and their invalid flags.
  logic [DATA_WIDTH-1:0] mem_data    [FRAM_DEPTH];
  logic                  mem_invalid [FRAM_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < FRAM_DEPTH; i++) begin
        mem_data[i]    <= '0;
        mem_invalid[i] <= 1'b0;
      end
    end else if (ctrl.wr) begin
      // Bus write wins over the external port.
      mem_data[ctrl.addr[ADDR_BITS-1:0]]    <= data_in;
      mem_invalid[ctrl.addr[ADDR_BITS-1:0]] <= attr_in.invalid;
    end else if (ext_wr) begin
      mem_data[ext_addr[ADDR_BITS-1:0]]    <= ext_data;
      mem_invalid[ext_addr[ADDR_BITS-1:0]] <= ext_attr.invalid;
    end
  end

  // Bus side read, zero when not selected.
  assign data_out = ctrl.oe ? mem_data[ctrl.addr[ADDR_BITS-1:0]] : '0;

  always_comb begin
    attr_out         = '0;
    attr_out.invalid = ctrl.oe & mem_invalid[ctrl.addr[ADDR_BITS-1:0]];
    // External read is always live.
    ext_rd_attr         = '0;
    ext_rd_attr.invalid = mem_invalid[ext_rd_addr[ADDR_BITS-1:0]];
  end

  assign ext_rd_data = mem_data[ext_rd_addr[ADDR_BITS-1:0]];

endmodule

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit
  #( parameter int PROG_DEPTH = 16
   )
  ( input  logic                  clk
  , input  logic                  rst
  , input  logic                  start
  , input  logic                  prog_wr
  , input  logic [3:0]            prog_addr
  , input  nitta_pkg::ctrl_word_t prog_word
  , output nitta_pkg::ctrl_word_t ctrl
  , output logic                  busy
  , output logic                  done
  );

  localparam int PC_BITS = $clog2(PROG_DEPTH);

  // Microprogram store, loaded one word per cycle from outside.
  nitta_pkg::ctrl_word_t prog_mem [PROG_DEPTH];
  // Current step.
  logic [PC_BITS-1:0]    pc;

  always_ff @(posedge clk) begin
    if (prog_wr) begin
      prog_mem[prog_addr[PC_BITS-1:0]] <= prog_word;
    end
  end

  // Strobes are all zero while idle.
  assign ctrl = busy ? prog_mem[pc] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      pc   <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        // A start pulse begins at step zero.
        if (start) begin
          busy <= 1'b1;
          pc   <= '0;
        end
      end else if (ctrl.last) begin
        // Final step executes now; done follows in the next cycle.
        busy <= 1'b0;
        done <= 1'b1;
        pc   <= '0;
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

endmodule

/* net_processor.sv */
`timescale 1ns/1ps

module net_processor
  #( parameter int DATA_WIDTH = nitta_pkg::data_width_default
   , parameter int FRAM_DEPTH = nitta_pkg::fram_depth_default
   , parameter int PROG_DEPTH = nitta_pkg::prog_depth_default
   )
  ( input  logic                  clk
  , input  logic                  rst
  , input  logic                  start
  , input  logic                  prog_wr
  , input  logic [3:0]            prog_addr
  , input  nitta_pkg::ctrl_word_t prog_word
  , input  logic                  ext_wr
  , input  logic [3:0]            ext_addr
  , input  logic [DATA_WIDTH-1:0] ext_data
  , input  nitta_pkg::attr_t      ext_attr
  , input  logic [3:0]            ext_rd_addr
  , output logic [DATA_WIDTH-1:0] ext_rd_data
  , output nitta_pkg::attr_t      ext_rd_attr
  , output logic                  busy
  , output logic                  done
  );

  nitta_pkg::ctrl_word_t ctrl;

  // Shared bus and the per-unit drives that form it.
  logic [DATA_WIDTH-1:0] bus_data;
  nitta_pkg::attr_t      bus_attr;
  logic [DATA_WIDTH-1:0] fram_data, mult_data, accum_data;
  nitta_pkg::attr_t      fram_attr, mult_attr, accum_attr;

  control_unit #(.PROG_DEPTH(PROG_DEPTH)) i_control_unit (
    .clk(clk), .rst(rst), .start(start), .prog_wr(prog_wr), .prog_addr(prog_addr),
    .prog_word(prog_word), .ctrl(ctrl), .busy(busy), .done(done)
  );

  pu_fram #(.DATA_WIDTH(DATA_WIDTH), .FRAM_DEPTH(FRAM_DEPTH)) i_pu_fram (
    .clk(clk), .rst(rst), .ctrl(ctrl.fram), .data_in(bus_data), .attr_in(bus_attr),
    .data_out(fram_data), .attr_out(fram_attr), .ext_wr(ext_wr), .ext_addr(ext_addr),
    .ext_data(ext_data), .ext_attr(ext_attr), .ext_rd_addr(ext_rd_addr),
    .ext_rd_data(ext_rd_data), .ext_rd_attr(ext_rd_attr)
  );

  pu_mult #(.DATA_WIDTH(DATA_WIDTH)) i_pu_mult (
    .clk(clk), .rst(rst), .signal_wr(ctrl.mult.wr), .signal_sel(ctrl.mult.sel),
    .signal_oe(ctrl.mult.oe), .data_in(bus_data), .attr_in(bus_attr),
    .data_out(mult_data), .attr_out(mult_attr)
  );

  pu_accum #(.DATA_WIDTH(DATA_WIDTH)) i_pu_accum (
    .clk(clk), .rst(rst), .signal_wr(ctrl.accum.wr), .signal_sel(ctrl.accum.sel),
    .signal_oe(ctrl.accum.oe), .data_in(bus_data), .attr_in(bus_attr),
    .data_out(accum_data), .attr_out(accum_attr)
  );

  // Idle units drive zero, so a plain OR forms the bus.
  assign bus_data = fram_data | mult_data | accum_data;
  assign bus_attr = fram_attr | mult_attr | accum_attr;

endmodule

/* tb_net_processor.sv */
`timescale 1ns/1ps

module tb_net_processor;

  localparam int DATA_WIDTH = nitta_pkg::data_width_default;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  start;
  logic                  prog_wr;
  logic [3:0]            prog_addr;
  nitta_pkg::ctrl_word_t prog_word;
  logic                  ext_wr;
  logic [3:0]            ext_addr;
  logic [DATA_WIDTH-1:0] ext_data;
  nitta_pkg::attr_t      ext_attr;
  logic [3:0]            ext_rd_addr;
  logic [DATA_WIDTH-1:0] ext_rd_data;
  nitta_pkg::attr_t      ext_rd_attr;
  logic                  busy;
  logic                  done;

  // Parsed trace commands, one entry per line.
  byte         cmd_q [$];
  logic [31:0] addr_q [$];
  logic [31:0] value_q [$];
  logic [31:0] inv_q [$];
  // Copy of the loaded microprogram, for the expected run length.
  logic [12:0] prog_copy [16];
  integer      seed = 32'h8ad4;
  int          n_cmds = 0;
  int          checks = 0;
  int          errors = 0;
  int          fd;
  int          code;
  string       line;
  byte         cmd;
  logic [31:0] a_val, v_val, i_val;

  net_processor #(
    .DATA_WIDTH(DATA_WIDTH)
  ) i_dut (
    .clk(clk), .rst(rst), .start(start), .prog_wr(prog_wr), .prog_addr(prog_addr),
    .prog_word(prog_word), .ext_wr(ext_wr), .ext_addr(ext_addr), .ext_data(ext_data),
    .ext_attr(ext_attr), .ext_rd_addr(ext_rd_addr), .ext_rd_data(ext_rd_data),
    .ext_rd_attr(ext_rd_attr), .busy(busy), .done(done)
  );

  always #4 clk = ~clk;

  // Idle cycles between commands, zero to three.
  task automatic idle_gap();
    int n;
    n = $unsigned($random(seed)) % 4;
    repeat (n) @(posedge clk);
  endtask

  task automatic load_step(input logic [3:0] addr, input logic [12:0] word);
    @(posedge clk);
    prog_wr   <= 1'b1;
    prog_addr <= addr;
    prog_word <= word;
    prog_copy[addr] = word;
    @(posedge clk);
    prog_wr <= 1'b0;
  endtask

  task automatic write_word(input logic [3:0] addr, input logic [7:0] value, input logic inv);
    @(posedge clk);
    ext_wr   <= 1'b1;
    ext_addr <= addr;
    ext_data <= value;
    ext_attr <= {3'b000, inv};
    @(posedge clk);
    ext_wr <= 1'b0;
  endtask

  // Combinational read port, sampled at the falling edge.
  task automatic compare_word(input logic [3:0] addr, input logic [7:0] value, input logic inv);
    @(posedge clk);
    ext_rd_addr <= addr;
    @(negedge clk);
    checks++;
    if (ext_rd_data !== value || ext_rd_attr !== {3'b000, inv}) begin
      $display("Fail at time %0t: word %0d reads %h/%b, expected %h/%b", $time, addr,
               ext_rd_data, ext_rd_attr.invalid, value, inv);
      errors++;
    end
  endtask

  // Start pulse, then count cycles until done.
  task automatic run_program();
    int steps;
    int cycles;
    steps = 1;
    // Steps run up to and including the one with the last bit.
    while (steps < 16 && !prog_copy[steps-1][0]) steps++;
    cycles = 0;
    @(posedge clk);
    start <= 1'b1;
    do begin
      @(posedge clk);
      start <= 1'b0;
      cycles++;
      @(negedge clk);
    end while (!done && cycles < 64);
    checks++;
    if (!done) begin
      $display("The program never finished: done stayed low after start");
      errors++;
    end else if (cycles != steps + 1) begin
      $display("Fail at time %0t: done after %0d cycles, expected %0d", $time, cycles,
               steps + 1);
      errors++;
    end
  endtask

  // Ends a run that stalls.
  initial begin
    wait (n_cmds > 0);
    repeat (n_cmds * 40) @(posedge clk);
    $display("Watchdog expired before the trace was finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    start       = 1'b0;
    prog_wr     = 1'b0;
    prog_addr   = '0;
    prog_word   = '0;
    ext_wr      = 1'b0;
    ext_addr    = '0;
    ext_data    = '0;
    ext_attr    = '0;
    ext_rd_addr = '0;
    for (int i = 0; i < 16; i++) prog_copy[i] = '0;

    // Lines starting with a hash are comments.
    fd = $fopen("net_processor_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file net_processor_trace.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line[0] != "#" && line[0] != "\n") begin
          code = $sscanf(line, "%c %h %h %h", cmd, a_val, v_val, i_val);
          cmd_q.push_back(cmd);
          addr_q.push_back(a_val);
          value_q.push_back(v_val);
          inv_q.push_back(i_val);
        end
      end
      $fclose(fd);
    end

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Reset state, before any command.
    @(negedge clk);
    checks++;
    if (busy !== 1'b0 || done !== 1'b0 || ext_rd_data !== '0) begin
      $display("Fail at time %0t: state after reset busy=%b done=%b data=%h", $time, busy,
               done, ext_rd_data);
      errors++;
    end

    n_cmds = cmd_q.size();
    for (int k = 0; k < n_cmds; k++) begin
      idle_gap();
      case (cmd_q[k])
        "P": load_step(addr_q[k][3:0], value_q[k][12:0]);
        "D": write_word(addr_q[k][3:0], value_q[k][7:0], inv_q[k][0]);
        "R": run_program();
        "E": compare_word(addr_q[k][3:0], value_q[k][7:0], inv_q[k][0]);
        default: begin
          $display("Unknown command in trace line %0d", k);
          errors++;
        end
      endcase
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* net_processor_trace.txt */
# P addr word | D addr value invalid | R | E addr value invalid
# All numbers in hex; invalid is 0 or 1; E compares the register file word.
P 0 840
P 1 8e0
P 2 000
P 3 000
P 4 1111
D 0 07 0
D 1 fd 0
E 0 07 0
R
E 2 eb 0
D 0 20 0
D 1 05 0
R
E 2 a0 1
D 0 03 1
D 1 04 0
R
E 2 0c 1
P 0 988
P 1 a0c
P 2 a8c
P 3 1303
D 3 10 0
D 4 25 0
D 5 f0 0
R
E 6 25 0
D 3 70 0
D 4 20 0
D 5 05 0
R
E 6 95 1

/* all.f */
nitta_pkg.sv
pu_mult_inner.sv
pu_mult.sv
pu_accum.sv
pu_fram.sv
control_unit.sv
net_processor.sv
tb_net_processor.sv
